/* logic/commit_cfg.svh */
`ifndef COMMIT_CFG_SVH
`define COMMIT_CFG_SVH

// id and data widths
`define COMMIT_ROB_LEN   6
`define COMMIT_WORD      32
`define COMMIT_AREG_LEN  5

`define COMMIT_CRMD_INIT 32'h8 // da=1, plv0, interrupts off

// exception codes written to estat.ecode
`define ECODE_INT  6'h00
`define ECODE_ADEF 6'h08
`define ECODE_INE  6'h0d
`define ECODE_SYS  6'h0b
`define ECODE_BRK  6'h0c
`define ECODE_ALE  6'h09
`endif

/* logic/commit_rob_pkg.sv */
`include "commit_cfg.svh"

package commit_rob_pkg;

    typedef logic [`COMMIT_ROB_LEN-1:0]  rob_rid_t;
    typedef logic [`COMMIT_AREG_LEN-1:0] arch_rid_t;
    typedef logic [`COMMIT_WORD-1:0]     word_t;

    // msb first, same order as trap priority
    typedef struct packed {
        logic intr;
        logic adef;
        logic ine;
        logic sys;
        logic brk;
        logic ale;
    } excp_t;

    typedef struct packed {
        word_t     pc;
        word_t     target_addr; // memory address for ale badv
        word_t     wdata;
        arch_rid_t wreg;
        logic      slot0_only;
        logic      lsu_uncached;
        logic      mem_write;
        excp_t     excp;
    } rob_entry_t;

    typedef struct packed {
        logic      commit; // write arf
        word_t     wdata;
        arch_rid_t warid;
        rob_rid_t  wrrid;
    } commit_out_t;

    typedef struct packed {
        logic  valid;
        excp_t excp;
        word_t pc;
        word_t target_addr;
    } trap_req_t;

endpackage

/* logic/commit_csr_pkg.sv */
`include "commit_cfg.svh"

package commit_csr_pkg;

    // trap related csrs only
    //   crmd  [1:0] plv, [2] ie, [3] da
    //   prmd  [2:0] saved plv/ie
    //   estat [21:16] ecode
    typedef struct packed {
        logic [`COMMIT_WORD-1:0] crmd;
        logic [`COMMIT_WORD-1:0] prmd;
        logic [`COMMIT_WORD-1:0] estat;
        logic [`COMMIT_WORD-1:0] era;  // pc of the trapping instruction
        logic [`COMMIT_WORD-1:0] badv; // faulting address for adef / ale
    } csr_t;

    typedef logic [5:0] ecode_t;

endpackage

/* logic/commit_fetch.sv */
`timescale 1ns/1ns

module commit_fetch
    import commit_rob_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic       [1:0] rob_valid_i,
    input  rob_entry_t [1:0] rob_entry_i,
    output logic       [1:0] rob_retire_o,
    input  logic             h_ready_i,
    output logic       [1:0] f_valid_o,
    output rob_entry_t [1:0] f_entry_o,
    output rob_rid_t   [1:0] f_rrid_o
);

    rob_rid_t         ptr_q;        // rrid of the rob head
    logic             skid_full_q;
    logic       [1:0] skid_valid_q;
    rob_entry_t [1:0] skid_entry_q;
    rob_rid_t   [1:0] skid_rrid_q;

    logic             bank_conflict;
    logic             slot1_hold;
    logic       [1:0] take;
    logic       [1:0] take_cnt;
    rob_rid_t   [1:0] head_rrid;

    // arf is banked on the low bit of the register id
    assign bank_conflict = rob_entry_i[1].wreg[0] == rob_entry_i[0].wreg[0];
    assign slot1_hold    = rob_entry_i[1].slot0_only | bank_conflict;

    assign take[0]  = rob_valid_i[0];
    assign take[1]  = rob_valid_i[1] & rob_valid_i[0] & ~slot1_hold;
    assign take_cnt = {1'b0, take[0]} + {1'b0, take[1]};

    assign head_rrid[0] = ptr_q;
    assign head_rrid[1] = ptr_q + rob_rid_t'(1);

    // nothing leaves the rob while the skid buffer holds a pair
    assign rob_retire_o = skid_full_q ? 2'b00 : take;

    assign f_valid_o = skid_full_q ? skid_valid_q : take;
    assign f_entry_o = skid_full_q ? skid_entry_q : rob_entry_i;
    assign f_rrid_o  = skid_full_q ? skid_rrid_q  : head_rrid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (!skid_full_q) begin
            ptr_q <= ptr_q + rob_rid_t'(take_cnt); // wraps mod 64
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            skid_full_q  <= 1'b0;
            skid_valid_q <= 2'b00;
        end else if (!skid_full_q) begin
            if (!h_ready_i && |take) begin
                skid_full_q  <= 1'b1;
                skid_valid_q <= take;
            end
        end else if (h_ready_i) begin
            skid_full_q  <= 1'b0; // buffered pair moved into h
            skid_valid_q <= 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (!skid_full_q) begin
            skid_entry_q <= rob_entry_i;
            skid_rrid_q  <= head_rrid;
        end
    end

endmodule

/* logic/commit_handle.sv */
`timescale 1ns/1ns

module commit_handle
    import commit_rob_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic        [1:0] f_valid_i,
    input  rob_entry_t  [1:0] f_entry_i,
    input  rob_rid_t    [1:0] f_rrid_i,
    output logic              h_ready_o,
    output logic              lsu_req_o,
    output logic              lsu_store_o,
    input  logic              lsu_ack_i,
    input  word_t             lsu_rdata_i,
    input  logic              rename_empty_i,
    output trap_req_t         trap_o,
    output logic        [1:0] retire_o,
    output commit_out_t [1:0] commit_o,
    output logic              flush_o
);

    typedef enum logic [2:0] {
        S_NORMAL,
        S_WAIT_ULOAD,
        S_WAIT_USTORE,
        S_WAIT_ACK_LOW, // previous ack still high, hold off the request
        S_WAIT_FLUSH
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic        [1:0] h_valid_q;
    rob_entry_t  [1:0] h_entry_q;
    rob_rid_t    [1:0] h_rrid_q;

    logic        [1:0] fault;
    logic              trap_sel;
    logic              trap_fire;
    logic              h_ready;
    logic              lsu_req;
    logic              lsu_store;
    logic        [1:0] retire;
    logic        [1:0] commit;
    logic              flush;
    word_t             data0;
    commit_out_t [1:0] commit_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_valid_q <= 2'b00;
        end else if (h_ready) begin
            h_valid_q <= f_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (h_ready) begin
            h_entry_q <= f_entry_i;
            h_rrid_q  <= f_rrid_i;
        end
    end

    assign fault[0] = h_valid_q[0] & (|h_entry_q[0].excp);
    assign fault[1] = h_valid_q[1] & (|h_entry_q[1].excp);
    assign trap_sel = ~fault[0]; // oldest faulting slot

    always_comb begin
        state_d   = state_q;
        h_ready   = 1'b1;
        retire    = 2'b00;
        commit    = 2'b00;
        flush     = 1'b0;
        trap_fire = 1'b0;
        lsu_req   = 1'b0;
        data0     = h_entry_q[0].wdata;
        case (state_q)
            S_NORMAL: begin
                if (h_valid_q[0] && h_entry_q[0].lsu_uncached && !fault[0]) begin
                    h_ready = 1'b0; // hold the pair during the access
                    if (lsu_ack_i) begin
                        state_d = S_WAIT_ACK_LOW;
                    end else if (h_entry_q[0].mem_write) begin
                        state_d = S_WAIT_USTORE;
                    end else begin
                        state_d = S_WAIT_ULOAD;
                    end
                end else begin
                    retire = h_valid_q;
                    // a fault kills itself and everything younger
                    commit = h_valid_q & ~{fault[1] | fault[0], fault[0]};
                    if (|fault) begin
                        trap_fire = 1'b1;
                        state_d   = S_WAIT_FLUSH;
                    end
                end
            end
            S_WAIT_ACK_LOW: begin
                h_ready = 1'b0;
                if (!lsu_ack_i) begin
                    state_d = h_entry_q[0].mem_write ? S_WAIT_USTORE : S_WAIT_ULOAD;
                end
            end
            S_WAIT_ULOAD: begin
                h_ready = 1'b0;
                lsu_req = !lsu_ack_i;
                if (lsu_ack_i) begin
                    h_ready = 1'b1;
                    retire  = h_valid_q;
                    commit  = 2'b01; // younger slot is flushed
                    data0   = lsu_rdata_i;
                    state_d = S_WAIT_FLUSH;
                end
            end
            S_WAIT_USTORE: begin
                h_ready = 1'b0;
                lsu_req = !lsu_ack_i;
                if (lsu_ack_i) begin
                    h_ready   = 1'b1;
                    retire    = h_valid_q;
                    commit    = h_valid_q & {~fault[1], 1'b1};
                    trap_fire = fault[1];
                    state_d   = fault[1] ? S_WAIT_FLUSH : S_NORMAL;
                end
            end
            S_WAIT_FLUSH: begin
                retire = h_valid_q; // drained, never written to arf
                flush  = 1'b1;
                if (rename_empty_i) begin
                    state_d = S_NORMAL;
                end
            end
            default: state_d = S_NORMAL;
        endcase
    end

    assign lsu_store = lsu_req & (state_q == S_WAIT_USTORE);
    assign h_ready_o = h_ready;

    // trap goes to csr_trap the same cycle, not through the output register
    always_comb begin
        trap_o.valid       = trap_fire;
        trap_o.excp        = h_entry_q[trap_sel].excp;
        trap_o.pc          = h_entry_q[trap_sel].pc;
        trap_o.target_addr = h_entry_q[trap_sel].target_addr;
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            commit_nxt[i].commit = commit[i];
            commit_nxt[i].wdata  = h_entry_q[i].wdata;
            commit_nxt[i].warid  = h_entry_q[i].wreg;
            commit_nxt[i].wrrid  = h_rrid_q[i];
        end
        commit_nxt[0].wdata = data0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= S_NORMAL;
            retire_o    <= 2'b00;
            commit_o    <= '0;
            flush_o     <= 1'b0;
            lsu_req_o   <= 1'b0;
            lsu_store_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            retire_o    <= retire;
            commit_o    <= commit_nxt;
            flush_o     <= flush;
            lsu_req_o   <= lsu_req;
            lsu_store_o <= lsu_store;
        end
    end

endmodule

/* logic/csr_trap.sv */
`timescale 1ns/1ns
`include "commit_cfg.svh"

module csr_trap
    import commit_rob_pkg::*;
    import commit_csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  trap_req_t trap_i,
    output csr_t      csr_o
);

    localparam csr_t CSR_RESET = '{crmd: `COMMIT_CRMD_INIT, default: '0};

    csr_t   csr_q;
    csr_t   csr_d;
    ecode_t ecode;
    word_t  badv_d;
    logic   badv_we;

    // first matching flag wins
    always_comb begin
        ecode   = '0;
        badv_we = 1'b0;
        badv_d  = trap_i.pc;
        case (1'b1)
            trap_i.excp.intr: ecode = `ECODE_INT;
            trap_i.excp.adef: begin
                ecode   = `ECODE_ADEF;
                badv_we = 1'b1; // bad fetch address is the pc itself
            end
            trap_i.excp.ine:  ecode = `ECODE_INE;
            trap_i.excp.sys:  ecode = `ECODE_SYS;
            trap_i.excp.brk:  ecode = `ECODE_BRK;
            trap_i.excp.ale: begin
                ecode   = `ECODE_ALE;
                badv_we = 1'b1;
                badv_d  = trap_i.target_addr;
            end
            default: ecode = '0;
        endcase
    end

    always_comb begin
        csr_d = csr_q;
        if (trap_i.valid) begin
            csr_d.estat[21:16] = ecode;
            csr_d.era          = trap_i.pc;
            csr_d.prmd[2:0]    = csr_q.crmd[2:0]; // save plv and ie
            csr_d.crmd[2:0]    = 3'b000;          // kernel mode, ints off
            if (badv_we) begin
                csr_d.badv = badv_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_q <= CSR_RESET;
        end else begin
            csr_q <= csr_d;
        end
    end

    assign csr_o = csr_q;

endmodule

/* logic/commit_unit.sv */
`timescale 1ns/1ns

module commit_unit
    import commit_rob_pkg::*;
    import commit_csr_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic        [1:0] rob_valid_i,
    input  rob_entry_t  [1:0] rob_entry_i,
    output logic        [1:0] rob_retire_o,
    output logic              lsu_req_o,
    output logic              lsu_store_o,
    input  logic              lsu_ack_i,
    input  word_t             lsu_rdata_i,
    input  logic              rename_empty_i,
    output logic        [1:0] retire_o,
    output commit_out_t [1:0] commit_o,
    output logic              flush_o,
    output csr_t              csr_o
);

    logic       [1:0] f_valid;
    rob_entry_t [1:0] f_entry;
    rob_rid_t   [1:0] f_rrid;
    logic             h_ready;
    trap_req_t        trap;

    commit_fetch u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .rob_valid_i  (rob_valid_i),
        .rob_entry_i  (rob_entry_i),
        .rob_retire_o (rob_retire_o),
        .h_ready_i    (h_ready),
        .f_valid_o    (f_valid),
        .f_entry_o    (f_entry),
        .f_rrid_o     (f_rrid)
    );

    commit_handle u_handle (
        .clk            (clk),
        .rst_n          (rst_n),
        .f_valid_i      (f_valid),
        .f_entry_i      (f_entry),
        .f_rrid_i       (f_rrid),
        .h_ready_o      (h_ready),
        .lsu_req_o      (lsu_req_o),
        .lsu_store_o    (lsu_store_o),
        .lsu_ack_i      (lsu_ack_i),
        .lsu_rdata_i    (lsu_rdata_i),
        .rename_empty_i (rename_empty_i),
        .trap_o         (trap),
        .retire_o       (retire_o),
        .commit_o       (commit_o),
        .flush_o        (flush_o)
    );

    csr_trap u_csr (
        .clk    (clk),
        .rst_n  (rst_n),
        .trap_i (trap),
        .csr_o  (csr_o)
    );

endmodule

/* testbench/commit_unit_assertions.sv */
`timescale 1ns/1ns

module commit_unit_assertions
    import commit_rob_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              lsu_req_o,
    input logic              lsu_ack_i,
    input logic              flush_o,
    input logic        [1:0] retire_o,
    input commit_out_t [1:0] commit_o
);

    // four-phase: request held until the lsu answers
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_req_o && !lsu_ack_i |=> lsu_req_o)
        else $error("lsu_req_o dropped before lsu_ack_i");

    no_commit_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush_o |-> !(commit_o[0].commit || commit_o[1].commit))
        else $error("commit while flush_o is high");

    slot1_after_slot0: assert property (@(posedge clk) disable iff (!rst_n)
        retire_o[1] |-> retire_o[0])
        else $error("slot 1 retired without slot 0");

endmodule

bind commit_unit commit_unit_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .lsu_req_o (lsu_req_o),
    .lsu_ack_i (lsu_ack_i),
    .flush_o   (flush_o),
    .retire_o  (retire_o),
    .commit_o  (commit_o)
);

/* testbench/commit_unit_tb.sv */
`timescale 1ns/1ns
`include "commit_cfg.svh"

module commit_unit_tb
    import commit_rob_pkg::*;
    import commit_csr_pkg::*;
();

    localparam int N_ENTRIES = 300;
    localparam int TIMEOUT   = 20 * N_ENTRIES + 200;

    typedef struct packed {
        logic      is_load; // data comes from the lsu
        word_t     wdata;
        arch_rid_t warid;
        rob_rid_t  wrrid;
    } exp_commit_t;

    logic              clk;
    logic              rst_n;
    logic        [1:0] rob_valid_i;
    rob_entry_t  [1:0] rob_entry_i;
    logic        [1:0] rob_retire_o;
    logic              lsu_req_o;
    logic              lsu_store_o;
    logic              lsu_ack_i;
    word_t             lsu_rdata_i;
    logic              rename_empty_i;
    logic        [1:0] retire_o;
    commit_out_t [1:0] commit_o;
    logic              flush_o;
    csr_t              csr_o;

    rob_entry_t  prog [N_ENTRIES];
    rob_entry_t  rob_q[$];
    exp_commit_t exp_commit_q[$];
    logic  [1:0] exp_retire_q[$]; // one retire mask per pair
    logic        exp_store_q[$];  // mem_write of each uncached access
    csr_t        exp_flush_q[$]; // csr value expected at each flush
    word_t       lsu_data_q[$];
    csr_t        ref_csr;
    int          errors = 0;
    int          cycles = 0;
    logic  [1:0] ret_s = 2'b00;

    commit_unit UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("FAIL %0t: run did not finish within %0d cycles", $time, TIMEOUT);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string what, input logic [159:0] got, input logic [159:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic rob_entry_t make_entry();
        rob_entry_t e;
        e             = '0;
        e.pc          = $urandom & 32'hffff_fffc;
        e.target_addr = $urandom;
        e.wdata       = $urandom;
        e.wreg        = arch_rid_t'($urandom);
        e.slot0_only  = ($urandom_range(0, 4) == 0);
        if ($urandom_range(0, 7) == 0) begin
            e.lsu_uncached = 1'b1;
            e.slot0_only   = 1'b1; // keeps uncached ops in slot 0
            e.mem_write    = 1'($urandom_range(0, 1));
        end else if ($urandom_range(0, 11) == 0) begin
            e.excp = excp_t'($urandom_range(1, 63));
        end
        return e;
    endfunction

    function automatic ecode_t ref_ecode(input excp_t x);
        if (x.intr) return `ECODE_INT;
        if (x.adef) return `ECODE_ADEF;
        if (x.ine)  return `ECODE_INE;
        if (x.sys)  return `ECODE_SYS;
        if (x.brk)  return `ECODE_BRK;
        return `ECODE_ALE;
    endfunction

    function automatic void ref_trap(input rob_entry_t e);
        ecode_t ec;
        ec                  = ref_ecode(e.excp);
        ref_csr.estat[21:16] = ec;
        ref_csr.era          = e.pc;
        ref_csr.prmd[2:0]    = ref_csr.crmd[2:0];
        ref_csr.crmd[2:0]    = 3'b000;
        if (ec == `ECODE_ADEF) ref_csr.badv = e.pc;
        if (ec == `ECODE_ALE)  ref_csr.badv = e.target_addr;
        exp_flush_q.push_back(ref_csr);
    endfunction

    // walks the program in rob order to build the expected streams
    function automatic void build_expected();
        int         i;
        int         n;
        logic       pair1;
        rob_rid_t   rrid;
        rob_entry_t e0;
        rob_entry_t e1;
        i    = 0;
        rrid = '0;
        while (i < N_ENTRIES) begin
            e0    = prog[i];
            e1    = (i + 1 < N_ENTRIES) ? prog[i+1] : '0;
            pair1 = (i + 1 < N_ENTRIES) && !e1.slot0_only && (e1.wreg[0] != e0.wreg[0]);
            n     = pair1 ? 2 : 1;
            exp_retire_q.push_back(pair1 ? 2'b11 : 2'b01);
            if (e0.lsu_uncached) exp_store_q.push_back(e0.mem_write);
            if (|e0.excp) begin
                ref_trap(e0); // younger slot killed
            end else if (e0.lsu_uncached && !e0.mem_write) begin
                exp_commit_q.push_back(exp_commit_t'{1'b1, e0.wdata, e0.wreg, rrid});
                exp_flush_q.push_back(ref_csr);
            end else begin
                exp_commit_q.push_back(exp_commit_t'{1'b0, e0.wdata, e0.wreg, rrid});
                if (pair1 && |e1.excp) begin
                    ref_trap(e1);
                end else if (pair1) begin
                    exp_commit_q.push_back(exp_commit_t'{1'b0, e1.wdata, e1.wreg,
                                                         rrid + rob_rid_t'(1)});
                end
            end
            rrid = rrid + rob_rid_t'(n);
            i    = i + n;
        end
    endfunction

    // rob model stops issuing after a flush cause until the flush is over
    initial begin : rob_model
        rob_entry_t e;
        logic       hold;
        logic       seen_flush;
        hold        = 1'b0;
        seen_flush  = 1'b0;
        rob_valid_i = 2'b00;
        rob_entry_i = '0;
        forever begin
            @(negedge clk);
            if (ret_s[0]) begin
                e = rob_q.pop_front();
                if (|e.excp || (e.lsu_uncached && !e.mem_write)) begin
                    hold       = 1'b1;
                    seen_flush = 1'b0;
                end
            end
            if (ret_s[1]) begin
                e = rob_q.pop_front();
                if (|e.excp) begin
                    hold       = 1'b1;
                    seen_flush = 1'b0;
                end
            end
            if (hold && flush_o) seen_flush = 1'b1;
            if (hold && seen_flush && !flush_o) hold = 1'b0;
            rob_valid_i[0] = rst_n && !hold && rob_q.size() > 0;
            rob_valid_i[1] = rst_n && !hold && rob_q.size() > 1;
            rob_entry_i[0] = rob_q.size() > 0 ? rob_q[0] : '0;
            rob_entry_i[1] = rob_q.size() > 1 ? rob_q[1] : '0;
            #1;
            ret_s = rst_n ? rob_retire_o : 2'b00;
        end
    end

    initial begin : lsu_model
        lsu_ack_i   = 1'b0;
        lsu_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (rst_n && lsu_req_o && !lsu_ack_i) begin
                if (exp_store_q.size() == 0) begin
                    $display("FAIL %0t: lsu request with no uncached access pending", $time);
                    $display("FAIL: see errors above");
                    $fatal(1, "extra lsu request");
                end
                check("lsu_store", lsu_store_o, exp_store_q.pop_front());
                repeat ($urandom_range(0, 7)) @(negedge clk);
                lsu_rdata_i = $urandom;
                lsu_ack_i   = 1'b1;
                if (!lsu_store_o) lsu_data_q.push_back(lsu_rdata_i);
                while (lsu_req_o) @(negedge clk);
                lsu_ack_i = 1'b0;
            end
        end
    end

    initial begin : rename_model
        rename_empty_i = 1'b0;
        forever begin
            @(negedge clk);
            if (flush_o) begin
                repeat ($urandom_range(1, 4)) @(negedge clk);
                rename_empty_i = 1'b1;
                while (flush_o) @(negedge clk);
                rename_empty_i = 1'b0;
            end
        end
    end

    initial begin : compare
        exp_commit_t ec;
        logic        prev_flush;
        prev_flush = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (retire_o != 2'b00) begin
                    if (exp_retire_q.size() == 0) begin
                        $display("FAIL %0t: retire_o is %b but nothing is left to retire",
                                 $time, retire_o);
                        $display("FAIL: see errors above");
                        $fatal(1, "extra retire");
                    end
                    check("retire_o", retire_o, exp_retire_q.pop_front());
                end
                for (int i = 0; i < 2; i++) begin
                    if (commit_o[i].commit) begin
                        check("retire with commit", retire_o[i], 1'b1);
                        if (exp_commit_q.size() == 0) begin
                            $display("FAIL %0t: slot %0d committed but nothing is left to commit",
                                     $time, i);
                            $display("FAIL: see errors above");
                            $fatal(1, "extra commit");
                        end
                        ec = exp_commit_q.pop_front();
                        if (ec.is_load) ec.wdata = lsu_data_q.pop_front();
                        check("wdata", commit_o[i].wdata, ec.wdata);
                        check("warid", commit_o[i].warid, ec.warid);
                        check("wrrid", commit_o[i].wrrid, ec.wrrid);
                    end
                end
                if (flush_o && !prev_flush) begin
                    if (exp_flush_q.size() == 0) begin
                        $display("FAIL %0t: flush started with no trap or uncached load", $time);
                        $display("FAIL: see errors above");
                        $fatal(1, "extra flush");
                    end
                    check("csr at flush", csr_o, exp_flush_q.pop_front());
                end
                prev_flush = flush_o;
            end
        end
    end

    initial begin
        void'($urandom(32'hb426_9ab6));
        rst_n = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            prog[i] = make_entry();
            rob_q.push_back(prog[i]);
        end
        ref_csr      = '0;
        ref_csr.crmd = `COMMIT_CRMD_INIT;
        build_expected();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (rob_q.size() != 0 || exp_commit_q.size() != 0 || exp_flush_q.size() != 0
               || exp_retire_q.size() != 0 || exp_store_q.size() != 0 || flush_o) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk); // catch late extra commits
        check("final csr", csr_o, ref_csr);
        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "errors found");
        end
    end

endmodule

/* commit_unit.f */
+incdir+logic
logic/commit_rob_pkg.sv
logic/commit_csr_pkg.sv
logic/commit_fetch.sv
logic/commit_handle.sv
logic/csr_trap.sv
logic/commit_unit.sv
testbench/commit_unit_assertions.sv
testbench/commit_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the commit_unit testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module commit_unit_tb -f commit_unit.f -o sim_commit_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_commit_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
    exit 0
fi
exit 1
